//--- logic/gmii_tx_defines.svh
// Macros for beat width, frame FIFO depth, minimum payload, preamble length and gap length
`ifndef GMII_TX_DEFINES_SVH
`define GMII_TX_DEFINES_SVH

// --------------------------------------------------
// Input beat geometry
// --------------------------------------------------

// Bytes carried by one input beat, which must be 1 or an even number
`define GMII_TX_BYTES 2

// Depth of the store-and-forward FIFO in beats
// With two-byte beats this holds 256 bytes of frame data
`define GMII_TX_FIFO_DEPTH 128

// --------------------------------------------------
// Ethernet framing constants
// --------------------------------------------------

// Shortest payload on the wire before the FCS is appended
`define GMII_TX_MIN_PAYLOAD 60

// Number of 0x55 bytes sent ahead of the SFD
`define GMII_TX_PREAMBLE_LEN 7

// Minimum idle byte times between the end of one FCS and the next preamble
`define GMII_TX_IPG_LEN 12

`endif

//--- logic/gmii_tx_pkg.sv
// Input beat, GMII bus and statistics structs plus the byte-wise CRC-32 update function
`include "gmii_tx_defines.svh"

package gmii_tx_pkg;

	// --------------------------------------------------
	// Bus and counter types
	// --------------------------------------------------

	// One beat from the upstream source
	// Byte 0 of data is the first one to go out on the wire
	// Keep bits are contiguous from byte 0 and only matter on the last beat
	typedef struct packed {
		logic [`GMII_TX_BYTES-1:0][7:0] data;
		logic [`GMII_TX_BYTES-1:0]      keep;
		logic                           last;
	} beat_t;

	// Transmit half of a GMII port, one byte per clock
	typedef struct packed {
		logic [7:0] txd;
		logic       txen;
		logic       txer;
	} gmii_t;

	// Running totals taken from the wire
	// Bytes counts everything after the SFD including pad and FCS
	typedef struct packed {
		logic [15:0] frames;
		logic [31:0] bytes;
	} stats_t;

	// --------------------------------------------------
	// CRC-32
	// --------------------------------------------------

	// Advances the Ethernet CRC by one byte
	// The polynomial is used in its reflected form 0xEDB88320
	// Bit 0 of the byte enters first, which is the order GMII puts bits on the line
	// That lets both the data and the final register go out without any bit reversal
	// The caller starts from all ones and sends the inverted state as the FCS
	function automatic logic [31:0] crc32_next(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		c = crc ^ {24'h000000, data};
		// One shift per data bit, folding in the polynomial whenever a one drops out
		for (int i = 0; i < 8; i++)
		begin
			if (c[0])
			begin
				c = (c >> 1) ^ 32'hEDB88320;
			end
			else
			begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

endpackage

//--- logic/gmii_tx_frame_fifo.sv
// Store-and-forward beat FIFO that only presents frames whose last beat has been written
`timescale 1ns/1ns
`include "gmii_tx_defines.svh"

module gmii_tx_frame_fifo
	import gmii_tx_pkg::*;
(
	input  logic  clk,
	input  logic  sresetn,

	// Upstream beats, which may stall at any point inside a frame
	input  beat_t in_beat,
	input  logic  in_valid,
	output logic  in_ready,

	// Downstream beats, unbroken from first beat to last
	output beat_t out_beat,
	output logic  out_valid,
	input  logic  out_ready
);

	localparam int DEPTH  = `GMII_TX_FIFO_DEPTH;
	localparam int ADDR_W = $clog2(DEPTH);

	// Occupancy value at which no more beats can be taken
	localparam logic [ADDR_W:0] FULL_CNT = DEPTH[ADDR_W:0];

	// Beat storage
	beat_t mem [DEPTH];

	// Pointers wrap on their own since the depth is a power of two
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;

	// Beats held, from empty to full
	logic [ADDR_W:0] beat_cnt;

	// Frames whose last beat is in memory and has not yet been read
	// In the worst case every stored beat closes a frame
	logic [ADDR_W:0] frame_cnt;

	logic wr_en;
	logic rd_en;
	logic frame_up;
	logic frame_dn;

	// --------------------------------------------------
	// Handshakes
	// --------------------------------------------------

	assign in_ready = (beat_cnt != FULL_CNT);
	assign wr_en    = in_valid && in_ready;

	// Nothing is offered until a whole frame sits in memory
	// The count cannot reach zero before that frame's last beat leaves
	// so valid holds steady for the full frame
	assign out_valid = (frame_cnt != '0);
	assign rd_en     = out_valid && out_ready;

	// The head beat is read straight from memory
	assign out_beat = mem[rd_ptr];

	// A frame completes on write of its last beat and retires on read of it
	assign frame_up = wr_en && in_beat.last;
	assign frame_dn = rd_en && out_beat.last;

	// --------------------------------------------------
	// Storage and pointers
	// --------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= in_beat;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			beat_cnt  <= '0;
			frame_cnt <= '0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// Occupancy is unchanged when a write and a read coincide
			if (wr_en && !rd_en)
			begin
				beat_cnt <= beat_cnt + 1'b1;
			end
			else if (!wr_en && rd_en)
			begin
				beat_cnt <= beat_cnt - 1'b1;
			end

			// Same for the frame count
			if (frame_up && !frame_dn)
			begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			else if (!frame_up && frame_dn)
			begin
				frame_cnt <= frame_cnt - 1'b1;
			end
		end
	end

endmodule

//--- logic/gmii_tx_mac.sv
// GMII transmit framing FSM for preamble, SFD, data, zero padding, FCS and inter-packet gap
`timescale 1ns/1ns
`include "gmii_tx_defines.svh"

module gmii_tx_mac
	import gmii_tx_pkg::*;
(
	input  logic  clk,
	input  logic  sresetn,

	// Frame source that keeps valid high for a whole frame once it rises
	input  beat_t beat,
	input  logic  valid,
	output logic  ready,

	// Registered GMII transmit bus
	output gmii_t gmii
);

	localparam int BYTES = `GMII_TX_BYTES;
	localparam int IDX_W = (BYTES > 1) ? $clog2(BYTES) : 1;

	// Wide enough to count the minimum payload, which is the longest count needed
	localparam int CTR_W = $clog2(`GMII_TX_MIN_PAYLOAD + 1);

	// Counter values on the final cycle of each counted state
	localparam logic [CTR_W-1:0] PRE_LAST = CTR_W'(`GMII_TX_PREAMBLE_LEN - 1);
	localparam logic [CTR_W-1:0] LEN_LAST = CTR_W'(`GMII_TX_MIN_PAYLOAD - 1);
	localparam logic [CTR_W-1:0] FCS_LAST = CTR_W'(3);
	// The count runs from zero up to this value and the wait state adds one more idle cycle
	localparam logic [CTR_W-1:0] IPG_LAST = CTR_W'(`GMII_TX_IPG_LEN - 2);

	// Position of the final byte slot within a beat
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(BYTES - 1);

	typedef enum logic [2:0] {
		S_WAIT,
		S_PREAMBLE,
		S_SFD,
		S_DATA,
		S_CRC,
		S_IPG
	} state_t;

	state_t state;
	state_t next_state;

	// Shared counter that restarts at zero on every state change
	logic [CTR_W-1:0] ctr;

	// Byte slot of the current beat being sent
	logic [IDX_W-1:0] byte_idx;

	// Set once the minimum payload has been sent
	logic length_ok;
	// Minimum reached either earlier or with the byte going out now
	logic len_reached;
	// Set after the last kept byte of the frame has been sent
	// The data state then keeps going with zero pad bytes
	logic last_byte_sent;
	// The current slot is the final one to send from this beat
	logic beat_done;

	logic [7:0]      cur_byte;
	logic [7:0]      tx_byte;
	logic [31:0]     crc;
	logic [3:0][7:0] fcs;

	logic [7:0] txd_q;
	logic       txen_q;

	// --------------------------------------------------
	// Byte selection
	// --------------------------------------------------

	// A beat is finished on its top slot or when no kept byte lies above this slot
	assign beat_done = (byte_idx == IDX_LAST) ||
		(beat.last && (((beat.keep >> byte_idx) >> 1) == '0));

	assign cur_byte = beat.data[byte_idx];

	// Zero bytes fill out a short frame once its data has gone
	assign tx_byte = last_byte_sent ? 8'h00 : cur_byte;

	// One pulse per beat as its last kept byte is loaded into the output register
	assign ready = (state == S_DATA) && !last_byte_sent && valid && beat_done;

	assign len_reached = length_ok || (ctr == LEN_LAST);

	// FCS is the inverted register and goes out least significant byte first
	assign fcs = ~crc;

	// Error signalling is never used
	assign gmii = '{txd: txd_q, txen: txen_q, txer: 1'b0};

	// --------------------------------------------------
	// Next state
	// --------------------------------------------------

	always_comb
	begin
		next_state = state;
		case (state)
			S_WAIT:
				if (valid)
					next_state = S_PREAMBLE;
			S_PREAMBLE:
				if (ctr == PRE_LAST)
					next_state = S_SFD;
			S_SFD:
				next_state = S_DATA;
			// Leave once the minimum length is met and the frame data is done
			// Data may have ended earlier or may end on this very byte
			S_DATA:
				if (len_reached && (last_byte_sent || (ready && beat.last)))
					next_state = S_CRC;
			S_CRC:
				if (ctr == FCS_LAST)
					next_state = S_IPG;
			S_IPG:
				if (ctr == IPG_LAST)
					next_state = S_WAIT;
			default:
				next_state = S_WAIT;
		endcase
	end

	// --------------------------------------------------
	// Control registers
	// --------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			state          <= S_WAIT;
			ctr            <= '0;
			byte_idx       <= '0;
			length_ok      <= 1'b0;
			last_byte_sent <= 1'b0;
			txen_q         <= 1'b0;
		end
		else
		begin
			state <= next_state;

			if (next_state != state)
			begin
				ctr <= '0;
			end
			else
			begin
				ctr <= ctr + 1'b1;
			end

			// Transmit enable covers preamble through FCS
			txen_q <= (state == S_PREAMBLE) || (state == S_SFD) ||
				(state == S_DATA) || (state == S_CRC);

			if (state == S_WAIT)
			begin
				byte_idx       <= '0;
				length_ok      <= 1'b0;
				last_byte_sent <= 1'b0;
			end

			if (state == S_DATA)
			begin
				length_ok <= len_reached;
				// Step through the beat and go back to slot 0 for the next one
				if (!last_byte_sent && valid)
				begin
					byte_idx <= beat_done ? '0 : byte_idx + 1'b1;
				end
				if (ready && beat.last)
				begin
					last_byte_sent <= 1'b1;
				end
			end
		end
	end

	// --------------------------------------------------
	// Output byte and CRC
	// --------------------------------------------------

	always_ff @(posedge clk)
	begin
		case (state)
			S_WAIT:
			begin
				txd_q <= 8'h00;
				crc   <= '1;
			end
			S_PREAMBLE:
				txd_q <= 8'h55;
			S_SFD:
				txd_q <= 8'hD5;
			// Pad bytes are covered by the CRC just like data
			S_DATA:
			begin
				txd_q <= tx_byte;
				crc   <= crc32_next(crc, tx_byte);
			end
			S_CRC:
				txd_q <= fcs[ctr[1:0]];
			default:
				txd_q <= 8'h00;
		endcase
	end

endmodule

//--- logic/gmii_tx_stats.sv
// Frame and byte counters taken from the GMII transmit bus
`timescale 1ns/1ns

module gmii_tx_stats
	import gmii_tx_pkg::*;
(
	input  logic   clk,
	input  logic   sresetn,

	// Bus being observed
	input  gmii_t  gmii,

	// Totals since reset
	output stats_t stats
);

	// Enable from the previous cycle for edge detection
	logic txen_d;

	// The SFD has gone by in the current burst
	logic sfd_seen;

	// Bytes of the current frame after the SFD
	logic [15:0] frame_bytes;

	// First idle cycle after a burst
	logic frame_end;

	assign frame_end = txen_d && !gmii.txen;

	// --------------------------------------------------
	// Counting
	// --------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			txen_d      <= 1'b0;
			sfd_seen    <= 1'b0;
			frame_bytes <= '0;
			stats       <= '0;
		end
		else
		begin
			txen_d <= gmii.txen;

			if (gmii.txen)
			begin
				// Preamble bytes never match 0xD5 so the first match is the SFD
				if (sfd_seen)
				begin
					frame_bytes <= frame_bytes + 1'b1;
				end
				else if (gmii.txd == 8'hD5)
				begin
					sfd_seen <= 1'b1;
				end
			end
			else
			begin
				// Idle clears the per-frame state for the next burst
				sfd_seen    <= 1'b0;
				frame_bytes <= '0;
			end

			// The frame's count is still held here on the cycle txen drops
			if (frame_end)
			begin
				stats.frames <= stats.frames + 1'b1;
				stats.bytes  <= stats.bytes + {16'h0000, frame_bytes};
			end
		end
	end

endmodule

//--- logic/gmii_tx_top.sv
// Transmit path top level with the frame FIFO, the framing MAC and the statistics block
`timescale 1ns/1ns

module gmii_tx_top
	import gmii_tx_pkg::*;
(
	input  logic   clk,
	input  logic   sresetn,

	// Beat input with valid and ready
	input  beat_t  in_beat,
	input  logic   in_valid,
	output logic   in_ready,

	// GMII transmit bus to the PHY
	output gmii_t  gmii,

	// Frame and byte totals
	output stats_t stats
);

	// --------------------------------------------------
	// FIFO to MAC
	// --------------------------------------------------

	beat_t mac_beat;
	logic  mac_valid;
	logic  mac_ready;

	// Holds each frame until it is complete
	gmii_tx_frame_fifo u_fifo (
		.clk       (clk),
		.sresetn   (sresetn),
		.in_beat   (in_beat),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_beat  (mac_beat),
		.out_valid (mac_valid),
		.out_ready (mac_ready)
	);

	// Frames the data onto the wire
	gmii_tx_mac u_mac (
		.clk     (clk),
		.sresetn (sresetn),
		.beat    (mac_beat),
		.valid   (mac_valid),
		.ready   (mac_ready),
		.gmii    (gmii)
	);

	// Counts what actually went out
	gmii_tx_stats u_stats (
		.clk     (clk),
		.sresetn (sresetn),
		.gmii    (gmii),
		.stats   (stats)
	);

endmodule

//--- tb/gmii_tx_clkgen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns

module gmii_tx_clkgen
(
	output logic clk,
	output logic sresetn
);

	// Free running clock with a 10 ns period
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	// Reset is held low for ten rising edges and released just after an edge
	initial
	begin
		sresetn = 1'b0;
		repeat (10) @(posedge clk);
		#1 sresetn = 1'b1;
	end

endmodule

//--- tb/gmii_tx_asserts.sv
// Concurrent assertions on the GMII output and the FIFO to MAC handshake, bound to the top level
`timescale 1ns/1ns

module gmii_tx_asserts
	import gmii_tx_pkg::*;
(
	input logic  clk,
	input logic  sresetn,
	input gmii_t gmii,
	input beat_t mac_beat,
	input logic  mac_valid,
	input logic  mac_ready
);

	// Number of assertion failures, read by the testbench at the end of the run
	int fail_cnt = 0;

	// --------------------------------------------------
	// Output bus
	// --------------------------------------------------

	// Error signalling is never used on this transmit path
	a_no_txer: assert property (@(posedge clk) !gmii.txer)
	else
	begin
		$error("gmii.txer was high");
		fail_cnt++;
	end

	// Once reset has been seen for a cycle the enable must be low
	a_txen_reset: assert property (@(posedge clk) (!sresetn && $past(!sresetn)) |-> !gmii.txen)
	else
	begin
		$error("gmii.txen was high during reset");
		fail_cnt++;
	end

	// --------------------------------------------------
	// FIFO to MAC
	// --------------------------------------------------

	// Valid holds from its rise until the last beat of the frame transfers
	a_valid_frame: assert property (@(posedge clk) disable iff (!sresetn)
		(mac_valid && !(mac_ready && mac_beat.last)) |=> mac_valid)
	else
	begin
		$error("mac_valid fell in the middle of a frame");
		fail_cnt++;
	end

endmodule

bind gmii_tx_top gmii_tx_asserts u_asserts (
	.clk       (clk),
	.sresetn   (sresetn),
	.gmii      (gmii),
	.mac_beat  (mac_beat),
	.mac_valid (mac_valid),
	.mac_ready (mac_ready)
);

//--- tb/gmii_tx_tb.sv
// Table-driven testbench with beat driver, GMII frame monitor, reference FCS and stats checks
`timescale 1ns/1ns
`include "gmii_tx_defines.svh"

module gmii_tx_tb
	import gmii_tx_pkg::*;
();

	localparam int BYTES     = `GMII_TX_BYTES;
	localparam int MIN_LEN   = `GMII_TX_MIN_PAYLOAD;
	localparam int NUM_TESTS = 4;

	// Each table row holds the frame count, payload lengths, back-to-back flag and expected stall
	typedef struct packed {
		logic [2:0]      n;
		logic [0:4][8:0] len;
		logic            b2b;
		logic            stall;
	} test_t;

	// Short padded frame, unpadded lengths, a back-to-back trio and a burst larger than the FIFO
	localparam test_t TESTS [NUM_TESTS] = '{
		'{n: 3'd1, len: {9'd20, 9'd0, 9'd0, 9'd0, 9'd0}, b2b: 1'b0, stall: 1'b0},
		'{n: 3'd2, len: {9'd75, 9'd60, 9'd0, 9'd0, 9'd0}, b2b: 1'b0, stall: 1'b0},
		'{n: 3'd3, len: {9'd64, 9'd33, 9'd100, 9'd0, 9'd0}, b2b: 1'b1, stall: 1'b0},
		'{n: 3'd5, len: {9'd200, 9'd180, 9'd220, 9'd150, 9'd190}, b2b: 1'b1, stall: 1'b1}
	};

	logic   clk;
	logic   sresetn;
	beat_t  in_beat;
	logic   in_valid;
	logic   in_ready;
	gmii_t  gmii;
	stats_t stats;

	// Expected wire bytes of all queued frames and the length of each frame
	logic [7:0] exp_q [$];
	int         exp_len_q [$];
	logic [7:0] got_q [$];

	int          errors;
	int          checks;
	int          errs_start;
	int          frames_seen;
	int          idle_cnt;
	int          cycle_cnt;
	int          timeout_limit;
	int          exp_frames;
	logic [31:0] exp_bytes;
	bit          in_burst;
	bit          stall_seen;

	gmii_tx_clkgen u_clkgen (
		.clk     (clk),
		.sresetn (sresetn)
	);

	gmii_tx_top u_dut (
		.clk      (clk),
		.sresetn  (sresetn),
		.in_beat  (in_beat),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.gmii     (gmii),
		.stats    (stats)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	// Bit-serial reflected CRC-32 that takes one data bit per step with bit 0 first
	function automatic logic [31:0] crc_bitwise(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int i = 0; i < 8; i++)
		begin
			fb = c[0] ^ data[i];
			c  = c >> 1;
			if (fb)
			begin
				c = c ^ 32'hEDB88320;
			end
		end
		return c;
	endfunction

	// Twice the wire time of every frame in the table plus a fixed margin
	function automatic int timeout_cycles();
		int total;
		int plen;
		total = 1000;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			for (int f = 0; f < int'(TESTS[t].n); f++)
			begin
				plen  = (int'(TESTS[t].len[f]) < MIN_LEN) ? MIN_LEN : int'(TESTS[t].len[f]);
				total = total + (plen + 24) * 2;
			end
		end
		return total;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// Queues the wire image of a random frame and then drives its beats
	task automatic send_frame(input int len);
		logic [7:0]  pay [$];
		logic [7:0]  d;
		logic [31:0] crc;
		beat_t       b;
		int          plen;
		int          nbeats;
		int          idx;
		for (int i = 0; i < len; i++)
		begin
			pay.push_back(8'($urandom()));
		end
		plen = (len < MIN_LEN) ? MIN_LEN : len;
		for (int i = 0; i < `GMII_TX_PREAMBLE_LEN; i++)
		begin
			exp_q.push_back(8'h55);
		end
		exp_q.push_back(8'hD5);
		// Payload and zero pad both go into the image and the CRC
		crc = 32'hFFFFFFFF;
		for (int i = 0; i < plen; i++)
		begin
			d = (i < len) ? pay[i] : 8'h00;
			exp_q.push_back(d);
			crc = crc_bitwise(crc, d);
		end
		crc = ~crc;
		for (int k = 0; k < 4; k++)
		begin
			exp_q.push_back(crc[8*k +: 8]);
		end
		exp_len_q.push_back(plen + 12);
		exp_frames++;
		exp_bytes = exp_bytes + 32'(plen + 4);

		nbeats = (len + BYTES - 1) / BYTES;
		for (int bi = 0; bi < nbeats; bi++)
		begin
			b = '0;
			for (int k = 0; k < BYTES; k++)
			begin
				idx = bi * BYTES + k;
				if (idx < len)
				begin
					b.data[k] = pay[idx];
					b.keep[k] = 1'b1;
				end
			end
			b.last   = (bi == nbeats - 1);
			in_beat  = b;
			in_valid = 1'b1;
			// Ready only changes on a clock edge so it is stable here
			while (!in_ready)
			begin
				stall_seen = 1'b1;
				@(posedge clk);
				#1;
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		in_beat  = '0;
	endtask

	task automatic wait_drain();
		while (exp_len_q.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// Compares the collected burst with the oldest expected frame
	task automatic compare_frame();
		int         len;
		int         start_err;
		logic [7:0] e;
		frames_seen++;
		if (exp_len_q.size() == 0)
		begin
			errors++;
			$display("frame %0d of %0d bytes appeared on gmii with no frame expected",
				frames_seen, got_q.size());
		end
		else
		begin
			len = exp_len_q.pop_front();
			check_value($sformatf("frame length (frame %0d)", frames_seen),
				32'(got_q.size()), 32'(len));
			start_err = errors;
			// Only the first wrong byte of a frame is reported
			for (int i = 0; i < len; i++)
			begin
				e = exp_q.pop_front();
				if (errors == start_err && i < got_q.size())
				begin
					check_value($sformatf("gmii.txd (frame %0d byte %0d)", frames_seen, i),
						{24'h000000, got_q[i]}, {24'h000000, e});
				end
			end
		end
		got_q.delete();
	endtask

	// --------------------------------------------------
	// Monitor and timeout
	// --------------------------------------------------

	always @(posedge clk)
	begin
		if (sresetn && gmii.txen)
		begin
			// The rise of txen starts a frame and the gap before it is checked here
			if (!in_burst)
			begin
				if (frames_seen > 0 && idle_cnt < `GMII_TX_IPG_LEN)
				begin
					errors++;
					$display("only %0d idle cycles before frame %0d where %0d are required",
						idle_cnt, frames_seen + 1, `GMII_TX_IPG_LEN);
				end
				in_burst = 1'b1;
			end
			got_q.push_back(gmii.txd);
		end
		else if (in_burst)
		begin
			compare_frame();
			in_burst = 1'b0;
			idle_cnt = 1;
		end
		else
		begin
			idle_cnt++;
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------

	initial
	begin
		in_beat       = '0;
		in_valid      = 1'b0;
		errors        = 0;
		checks        = 0;
		frames_seen   = 0;
		idle_cnt      = 0;
		cycle_cnt     = 0;
		exp_frames    = 0;
		exp_bytes     = '0;
		in_burst      = 1'b0;
		timeout_limit = timeout_cycles();
		void'($urandom(62515));

		@(posedge sresetn);
		@(posedge clk);
		#1;
		check_value("in_ready", 32'(in_ready), 32'd1);
		check_value("stats.frames", 32'(stats.frames), 32'd0);
		check_value("stats.bytes", stats.bytes, 32'd0);

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			errs_start = errors;
			stall_seen = 1'b0;
			for (int f = 0; f < int'(TESTS[t].n); f++)
			begin
				send_frame(int'(TESTS[t].len[f]));
				if (!TESTS[t].b2b)
				begin
					wait_drain();
				end
			end
			wait_drain();
			// Counters follow one cycle after txen falls
			repeat (2) @(posedge clk);
			#1;
			check_value("stats.frames", 32'(stats.frames), 32'(exp_frames));
			check_value("stats.bytes", stats.bytes, exp_bytes);
			if (TESTS[t].stall && !stall_seen)
			begin
				errors++;
				$display("in_ready never went low during the burst of test %0d", t);
			end
			$display("test %0d %s: %0d frame(s), %0d error(s)", t,
				TESTS[t].b2b ? "back-to-back" : "one at a time", TESTS[t].n, errors - errs_start);
		end

		errors = errors + u_dut.u_asserts.fail_cnt;
		$display("tests %0d, checks %0d, frames %0d, assertion failures %0d, errors %0d",
			NUM_TESTS, checks, frames_seen, u_dut.u_asserts.fail_cnt, errors);
		if (errors == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- gmii_tx.f
+incdir+logic
logic/gmii_tx_pkg.sv
logic/gmii_tx_frame_fifo.sv
logic/gmii_tx_mac.sv
logic/gmii_tx_stats.sv
logic/gmii_tx_top.sv
tb/gmii_tx_clkgen.sv
tb/gmii_tx_asserts.sv
tb/gmii_tx_tb.sv

//--- Makefile
# Verilator build and run for the GMII transmit path

VERILATOR ?= verilator
TOP       ?= gmii_tx_tb
FILELIST  ?= gmii_tx.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ns
PASS_TEXT ?= *** PASSED ***

# Sources come from the file list, include directories are dropped
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The output is shown and then searched for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
